// File: hw/tscPkg.sv
package tscPkg;

	////////////////////////////////////////////////////////////////////////////
	// Machine dimensions
	////////////////////////////////////////////////////////////////////////////

	localparam int WordSize = 16;	// Data, address and instruction width
	localparam int RegCount = 4;
	localparam int LinkReg = 2;	// Written by JAL and JRL

	////////////////////////////////////////////////////////////////////////////
	// Instruction encodings
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [3:0] {
		opBne = 4'd0,
		opBeq = 4'd1,
		opBgz = 4'd2,
		opBlz = 4'd3,
		opAdi = 4'd4,
		opOri = 4'd5,
		opLhi = 4'd6,
		opLwd = 4'd7,
		opSwd = 4'd8,
		opJmp = 4'd9,
		opJal = 4'd10,
		opRtype = 4'd15
	} opcodeE;

	typedef enum logic [5:0] {
		fnAdd = 6'd0,
		fnSub = 6'd1,
		fnAnd = 6'd2,
		fnOrr = 6'd3,
		fnNot = 6'd4,
		fnTcp = 6'd5,
		fnShl = 6'd6,
		fnShr = 6'd7,
		fnJpr = 6'd25,
		fnJrl = 6'd26,
		fnWwd = 6'd28,
		fnHlt = 6'd29
	} funcE;

	// Same order as function codes 0 to 7
	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluNot,
		aluTcp,
		aluShl,
		aluShr
	} aluOpE;

	////////////////////////////////////////////////////////////////////////////
	// Sequencer
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [2:0] {
		stateFetchReq,
		stateFetchRel,
		stateExecute,
		stateMemReq,
		stateMemRel,
		stateWriteBack,
		stateHalt
	} cpuStateE;

endpackage

// File: hw/ctrlBus.sv
`timescale 1ns/1ps

interface ctrlBus;
	import tscPkg::*;

	logic regWrite;
	logic aluSrcImm;	// ALU operand b is the immediate
	aluOpE aluOp;
	logic memRead;
	logic memWrite;
	logic memToReg;
	logic branch;
	logic jump;
	logic jumpReg;	// Target taken from rs
	logic link;	// Write PC+1 to the link register
	logic outputWord;
	logic haltOp;
	logic immZeroExt;
	logic loadHigh;
	logic destIsRd;

	modport decoder (
		output regWrite, aluSrcImm, aluOp, memRead, memWrite, memToReg,
		branch, jump, jumpReg, link, outputWord, haltOp,
		immZeroExt, loadHigh, destIsRd
	);

	modport datapath (
		input regWrite, aluSrcImm, aluOp, memRead, memWrite, memToReg,
		branch, jump, jumpReg, link, outputWord, haltOp,
		immZeroExt, loadHigh, destIsRd
	);

endinterface

// File: hw/controlUnit.sv
`timescale 1ns/1ps

module controlUnit (
	input logic [tscPkg::WordSize-1:0] instruction,
	ctrlBus.decoder ctrl
);
	import tscPkg::*;

	opcodeE opcode;
	funcE func;

	assign opcode = opcodeE'(instruction[15:12]);
	assign func = funcE'(instruction[5:0]);

	always_comb begin
		ctrl.regWrite = 1'b0;
		ctrl.aluSrcImm = 1'b0;
		ctrl.aluOp = aluAdd;
		ctrl.memRead = 1'b0;
		ctrl.memWrite = 1'b0;
		ctrl.memToReg = 1'b0;
		ctrl.branch = 1'b0;
		ctrl.jump = 1'b0;
		ctrl.jumpReg = 1'b0;
		ctrl.link = 1'b0;
		ctrl.outputWord = 1'b0;
		ctrl.haltOp = 1'b0;
		ctrl.immZeroExt = 1'b0;
		ctrl.loadHigh = 1'b0;
		ctrl.destIsRd = 1'b0;

		case (opcode)
			opRtype: begin
				case (func)
					fnAdd, fnSub, fnAnd, fnOrr, fnNot, fnTcp, fnShl, fnShr: begin
						ctrl.regWrite = 1'b1;
						ctrl.destIsRd = 1'b1;
						ctrl.aluOp = aluOpE'(instruction[2:0]);	// Codes line up
					end
					fnJpr: ctrl.jumpReg = 1'b1;
					fnJrl: begin
						ctrl.jumpReg = 1'b1;
						ctrl.link = 1'b1;
						ctrl.regWrite = 1'b1;
					end
					fnWwd: ctrl.outputWord = 1'b1;
					fnHlt: ctrl.haltOp = 1'b1;
					default: ;	// Unknown function runs as a no-op
				endcase
			end
			opAdi: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
			end
			opOri: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.immZeroExt = 1'b1;
				ctrl.aluOp = aluOr;
			end
			opLhi: begin
				ctrl.regWrite = 1'b1;
				ctrl.loadHigh = 1'b1;
			end
			opLwd: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;	// Address is rs + imm
				ctrl.memRead = 1'b1;
				ctrl.memToReg = 1'b1;
			end
			opSwd: begin
				ctrl.aluSrcImm = 1'b1;
				ctrl.memWrite = 1'b1;
			end
			opBne, opBeq, opBgz, opBlz: ctrl.branch = 1'b1;	// Compare rs with rt
			opJmp: ctrl.jump = 1'b1;
			opJal: begin
				ctrl.jump = 1'b1;
				ctrl.link = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

// File: hw/alu.sv
`timescale 1ns/1ps

module alu (
	input logic [tscPkg::WordSize-1:0] a,
	input logic [tscPkg::WordSize-1:0] b,
	input tscPkg::aluOpE aluOp,
	input tscPkg::opcodeE opcode,
	output logic [tscPkg::WordSize-1:0] result,
	output logic branchTaken
);
	import tscPkg::*;

	always_comb begin
		case (aluOp)
			aluAdd: result = a + b;
			aluSub: result = a - b;
			aluAnd: result = a & b;
			aluOr: result = a | b;
			aluNot: result = ~a;
			aluTcp: result = ~a + 1'b1;
			aluShl: result = {a[WordSize-2:0], 1'b0};
			aluShr: result = {1'b0, a[WordSize-1:1]};	// Logical, zero fill
			default: result = '0;
		endcase
	end

	// Branch conditions
	always_comb begin
		case (opcode)
			opBne: branchTaken = (a != b);
			opBeq: branchTaken = (a == b);
			opBgz: branchTaken = !a[WordSize-1] && (a != '0);
			opBlz: branchTaken = a[WordSize-1];
			default: branchTaken = 1'b0;
		endcase
	end

endmodule

// File: hw/registerFile.sv
`timescale 1ns/1ps

module registerFile (
	input logic clk,
	input logic reset,
	input logic [$clog2(tscPkg::RegCount)-1:0] readAddrA,
	input logic [$clog2(tscPkg::RegCount)-1:0] readAddrB,
	output logic [tscPkg::WordSize-1:0] readDataA,
	output logic [tscPkg::WordSize-1:0] readDataB,
	input logic writeEnable,
	input logic [$clog2(tscPkg::RegCount)-1:0] writeAddr,
	input logic [tscPkg::WordSize-1:0] writeData
);
	import tscPkg::*;

	logic [WordSize-1:0] regs [RegCount];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < RegCount; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEnable) begin
			regs[writeAddr] <= writeData;
		end
	end

	// Reads see the old value during the write cycle
	assign readDataA = regs[readAddrA];
	assign readDataB = regs[readAddrB];

endmodule

// File: hw/cpuDatapath.sv
`timescale 1ns/1ps

module cpuDatapath (
	input logic clk,
	input logic reset,
	ctrlBus.datapath ctrl,
	output logic [tscPkg::WordSize-1:0] instruction,
	output logic memReq,
	output logic memWrite,
	output logic [tscPkg::WordSize-1:0] memAddress,
	output logic [tscPkg::WordSize-1:0] memWriteData,
	input logic memAck,
	input logic [tscPkg::WordSize-1:0] memReadData,
	output logic [tscPkg::WordSize-1:0] outputPort,
	output logic outputValid,
	output logic halted
);
	import tscPkg::*;

	cpuStateE state;
	logic [WordSize-1:0] pc;
	logic [WordSize-1:0] ir;
	logic [WordSize-1:0] mdr;	// Load data
	logic [WordSize-1:0] aluOut;
	logic [$clog2(RegCount)-1:0] rs, rt, rd;
	logic [$clog2(RegCount)-1:0] writeAddr;
	logic [WordSize-1:0] readDataA, readDataB;
	logic [WordSize-1:0] immExt;
	logic [WordSize-1:0] aluB, aluResult;
	logic [WordSize-1:0] writeData;
	logic [WordSize-1:0] pcPlusOne, nextPc;
	logic branchTaken;
	logic memPhase;
	logic ackSeen;

	assign instruction = ir;
	assign rs = ir[11:10];
	assign rt = ir[9:8];
	assign rd = ir[7:6];

	assign immExt = ctrl.immZeroExt ? {8'h00, ir[7:0]} : {{8{ir[7]}}, ir[7:0]};
	assign aluB = ctrl.aluSrcImm ? immExt : readDataB;

	registerFile registerFile_inst (
		.clk(clk),
		.reset(reset),
		.readAddrA(rs),
		.readAddrB(rt),
		.readDataA(readDataA),
		.readDataB(readDataB),
		.writeEnable(state == stateWriteBack && ctrl.regWrite),
		.writeAddr(writeAddr),
		.writeData(writeData)
	);

	alu alu_inst (
		.a(readDataA),
		.b(aluB),
		.aluOp(ctrl.aluOp),
		.opcode(opcodeE'(ir[15:12])),
		.result(aluResult),
		.branchTaken(branchTaken)
	);

	////////////////////////////////////////////////////////////////////////////
	// Writeback and next PC
	////////////////////////////////////////////////////////////////////////////

	assign writeAddr = ctrl.link ? LinkReg[$clog2(RegCount)-1:0] : (ctrl.destIsRd ? rd : rt);

	always_comb begin
		if (ctrl.link)
			writeData = pcPlusOne;
		else if (ctrl.loadHigh)
			writeData = {ir[7:0], 8'h00};
		else if (ctrl.memToReg)
			writeData = mdr;
		else
			writeData = aluOut;
	end

	assign pcPlusOne = pc + 1'b1;

	always_comb begin
		if (ctrl.jumpReg)
			nextPc = readDataA;
		else if (ctrl.jump)
			nextPc = {pc[WordSize-1:12], ir[11:0]};
		else if (ctrl.branch && branchTaken)
			nextPc = pcPlusOne + immExt;
		else
			nextPc = pcPlusOne;
	end

	////////////////////////////////////////////////////////////////////////////
	// Sequencer and memory handshake
	////////////////////////////////////////////////////////////////////////////

	assign memPhase = (state == stateMemReq) || (state == stateMemRel);
	assign ackSeen = memReq && memAck;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= stateFetchReq;
			memReq <= 1'b0;
			pc <= '0;
		end else begin
			case (state)
				stateFetchReq, stateMemReq: begin
					if (!memReq && !memAck) begin
						memReq <= 1'b1;	// Previous handshake fully closed
					end else if (ackSeen) begin
						memReq <= 1'b0;
						if (state == stateFetchReq)
							state <= stateFetchRel;
						else
							state <= stateMemRel;
					end
				end
				stateFetchRel: if (!memAck) state <= stateExecute;
				stateExecute: begin
					if (ctrl.memRead || ctrl.memWrite)
						state <= stateMemReq;
					else
						state <= stateWriteBack;
				end
				stateMemRel: if (!memAck) state <= stateWriteBack;
				stateWriteBack: begin
					pc <= nextPc;
					if (ctrl.haltOp)
						state <= stateHalt;
					else
						state <= stateFetchReq;
				end
				default: state <= stateHalt;	// Stays here until reset
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == stateFetchReq && ackSeen) ir <= memReadData;
		if (state == stateMemReq && ackSeen) mdr <= memReadData;
		if (state == stateExecute) aluOut <= aluResult;
	end

	assign memAddress = memPhase ? aluOut : pc;
	assign memWrite = memPhase && ctrl.memWrite;
	assign memWriteData = readDataB;	// Store data comes from rt

	assign outputPort = readDataA;
	assign outputValid = (state == stateWriteBack) && ctrl.outputWord;
	assign halted = (state == stateHalt) || (state == stateWriteBack && ctrl.haltOp);

	addressHeld: assert property (@(posedge clk) disable iff (reset)
		memReq |=> !memReq || $stable(memAddress))
		else $error("memAddress changed during a request");

	noReqOverAck: assert property (@(posedge clk) disable iff (reset)
		(!memReq && memAck) |=> !memReq)
		else $error("memReq raised while memAck still high");

endmodule

// File: hw/tscCpu.sv
`timescale 1ns/1ps

module tscCpu (
	input logic clk,
	input logic reset,
	output logic memReq,
	output logic memWrite,
	output logic [tscPkg::WordSize-1:0] memAddress,
	output logic [tscPkg::WordSize-1:0] memWriteData,
	input logic memAck,
	input logic [tscPkg::WordSize-1:0] memReadData,
	output logic [tscPkg::WordSize-1:0] outputPort,
	output logic outputValid,
	output logic halted
);
	import tscPkg::*;

	logic [WordSize-1:0] instruction;

	ctrlBus ctrlIf ();

	controlUnit controlUnit_inst (
		.instruction(instruction),
		.ctrl(ctrlIf.decoder)
	);

	cpuDatapath cpuDatapath_inst (
		.clk(clk),
		.reset(reset),
		.ctrl(ctrlIf.datapath),
		.instruction(instruction),
		.memReq(memReq),
		.memWrite(memWrite),
		.memAddress(memAddress),
		.memWriteData(memWriteData),
		.memAck(memAck),
		.memReadData(memReadData),
		.outputPort(outputPort),
		.outputValid(outputValid),
		.halted(halted)
	);

endmodule

// File: bench/isaModel.svh
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

////////////////////////////////////////////////////////////////////////////
// Architectural state of the instruction-level model
////////////////////////////////////////////////////////////////////////////

logic [15:0] modelPc;
logic [15:0] modelRegs [4];
logic [15:0] modelMem [256];
logic modelHalted;
logic [15:0] modelOutputs [$];	// WWD values in program order

task automatic modelReset();
	modelPc = '0;
	modelHalted = 1'b0;
	modelOutputs.delete();
	for (int i = 0; i < 4; i++) begin
		modelRegs[i] = '0;
	end
endtask

// One instruction, straight from the ISA field and operand rules
task automatic modelStep();
	logic [15:0] inst;
	logic [15:0] a, b, imm, next;
	logic [3:0] op;
	logic [5:0] fn;
	logic [1:0] rt, rd;

	inst = modelMem[modelPc[7:0]];
	op = inst[15:12];
	fn = inst[5:0];
	rt = inst[9:8];
	rd = inst[7:6];
	a = modelRegs[inst[11:10]];
	b = modelRegs[rt];
	imm = {{8{inst[7]}}, inst[7:0]};
	next = modelPc + 16'd1;
	case (op)
		opRtype: begin
			case (fn)
				fnAdd: modelRegs[rd] = a + b;
				fnSub: modelRegs[rd] = a - b;
				fnAnd: modelRegs[rd] = a & b;
				fnOrr: modelRegs[rd] = a | b;
				fnNot: modelRegs[rd] = ~a;
				fnTcp: modelRegs[rd] = 16'd0 - a;
				fnShl: modelRegs[rd] = a << 1;
				fnShr: modelRegs[rd] = a >> 1;
				fnJpr: next = a;
				fnJrl: begin
					modelRegs[LinkReg] = modelPc + 16'd1;
					next = a;	// Old rs, read before the link write
				end
				fnWwd: modelOutputs.push_back(a);
				fnHlt: modelHalted = 1'b1;
				default: ;
			endcase
		end
		opAdi: modelRegs[rt] = a + imm;
		opOri: modelRegs[rt] = a | {8'h00, inst[7:0]};
		opLhi: modelRegs[rt] = {inst[7:0], 8'h00};
		opLwd: modelRegs[rt] = modelMem[8'(a + imm)];
		opSwd: modelMem[8'(a + imm)] = b;
		opBne: if (a != b) next = next + imm;
		opBeq: if (a == b) next = next + imm;
		opBgz: if ($signed(a) > 0) next = next + imm;
		opBlz: if ($signed(a) < 0) next = next + imm;
		opJmp: next = {modelPc[15:12], inst[11:0]};
		opJal: begin
			modelRegs[LinkReg] = next;
			next = {modelPc[15:12], inst[11:0]};
		end
		default: ;
	endcase
	modelPc = next;
endtask

task automatic modelRun(input int maxSteps);
	int steps;

	steps = 0;
	while (!modelHalted && steps < maxSteps) begin
		modelStep();
		steps++;
	end
endtask

`endif

// File: bench/tscCpuTb.sv
`timescale 1ns/1ps

module tscCpuTb;
	import tscPkg::*;

	localparam int ResetCycles = 10;
	localparam int HaltWatch = 20;	// Idle cycles checked after HLT
	localparam int ProgTarget = 40;
	localparam int CyclesPerInstr = 40;

	logic clk;
	logic reset;
	logic memReq, memWrite, memAck;
	logic [WordSize-1:0] memAddress, memWriteData, memReadData;
	logic [WordSize-1:0] outputPort;
	logic outputValid, halted;

	logic [15:0] mem [256];
	int seed;
	int progLen, errorCount, passCount, failCount;
	int outputCount, expectedCount;
	int cycleCount = 0;
	int cycleLimit = 0;
	logic firstRequest, lastReq, lastAck;
	logic [WordSize-1:0] lastAddress;

	`include "isaModel.svh"

	tscCpu tscCpu_inst (
		.clk(clk),
		.reset(reset),
		.memReq(memReq),
		.memWrite(memWrite),
		.memAddress(memAddress),
		.memWriteData(memWriteData),
		.memAck(memAck),
		.memReadData(memReadData),
		.outputPort(outputPort),
		.outputValid(outputValid),
		.halted(halted)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic int randRange(input int lo, input int hi);
		logic [31:0] r;

		r = $random(seed);
		return lo + int'(r % (hi - lo + 1));
	endfunction

	function automatic logic [15:0] rType(input logic [1:0] rs, input logic [1:0] rt,
			input logic [1:0] rd, input funcE fn);
		return {opRtype, rs, rt, rd, fn};
	endfunction

	function automatic logic [15:0] iType(input opcodeE op, input logic [1:0] rs,
			input logic [1:0] rt, input logic [7:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [15:0] jType(input opcodeE op, input int target);
		return {op, 12'(target)};
	endfunction

	task automatic expectTrue(input bit ok, input string what);
		assert (ok) else begin
			$display("Fail at %0t: %s", $time, what);
			errorCount++;
		end
	endtask

	task automatic emit(input logic [15:0] word);
		mem[progLen] = word;
		progLen++;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Program generators
	////////////////////////////////////////////////////////////////////////////

	task automatic addAluChunk();
		int form;
		logic [1:0] rs, rt, rd;
		logic [7:0] imm;

		form = randRange(0, 3);
		rs = 2'(randRange(0, 3));
		rt = 2'(randRange(0, 3));
		rd = 2'(randRange(0, 3));
		imm = 8'(randRange(0, 255));
		case (form)
			0: begin
				emit(rType(rs, rt, rd, funcE'(randRange(0, 7))));
				emit(rType(rd, 0, 0, fnWwd));
			end
			1: emit(iType(opAdi, rs, rt, imm));
			2: emit(iType(opOri, rs, rt, imm));
			default: emit(iType(opLhi, 0, rt, imm));
		endcase
		if (form != 0) emit(rType(rt, 0, 0, fnWwd));
	endtask

	// Base register lands in 136..247 so rb+offset stays in the data half
	task automatic addMemoryChunk();
		logic [1:0] rb, rv, rl;
		logic [7:0] offStore, offLoad;

		rb = 2'(randRange(0, 3));
		rv = rb + 2'(randRange(1, 3));
		rl = rb + 2'(randRange(1, 3));
		offStore = 8'(randRange(-8, 7));
		offLoad = randRange(0, 1) ? offStore : 8'(randRange(-8, 7));
		emit(iType(opLhi, 0, rb, 8'h00));
		emit(iType(opOri, rb, rb, 8'(randRange(136, 247))));
		emit(iType(opLhi, 0, rv, 8'(randRange(0, 255))));
		emit(iType(opOri, rv, rv, 8'(randRange(0, 255))));
		emit(iType(opSwd, rb, rv, offStore));
		emit(iType(opLwd, rb, rl, offLoad));
		emit(rType(rl, 0, 0, fnWwd));
	endtask

	task automatic addFlowChunk();
		int form, skip;
		logic [1:0] ra, rb;

		form = randRange(0, 4);
		skip = randRange(1, 3);
		ra = 2'(randRange(0, 3));
		rb = 2'(randRange(0, 3));
		case (form)
			0: begin
				emit(iType(opAdi, ra, ra, 8'(randRange(0, 255))));
				emit(iType(opcodeE'(randRange(0, 3)), ra, rb, 8'(skip)));
			end
			1: emit(jType(opJmp, progLen + 1 + skip));
			2: emit(jType(opJal, progLen + 1 + skip));
			default: begin
				emit(iType(opLhi, 0, ra, 8'h00));
				emit(iType(opOri, ra, ra, 8'(progLen + 2 + skip)));	// Jump lands past skips
				emit(rType(ra, 0, 0, form == 3 ? fnJpr : fnJrl));
			end
		endcase
		repeat (skip) emit(rType(2'(randRange(0, 3)), 0, 0, fnWwd));	// Path markers
		emit(rType(LinkReg, 0, 0, fnWwd));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////

	task automatic runTest(input string name, input int kind);
		int errorsBefore;

		errorsBefore = errorCount;
		for (int i = 0; i < 256; i++) begin
			mem[i] = {~i[7:0], i[7:0]};
		end
		progLen = 0;
		while (progLen < ProgTarget) begin
			case (kind == 3 ? randRange(0, 2) : kind)
				0: addAluChunk();
				1: addMemoryChunk();
				default: addFlowChunk();
			endcase
		end
		emit(rType(0, 0, 0, fnHlt));
		modelMem = mem;
		modelReset();
		modelRun(2 * progLen);
		expectedCount = modelOutputs.size();
		cycleLimit += CyclesPerInstr * progLen + ResetCycles + HaltWatch;

		@(posedge clk);
		#1 reset = 1'b1;
		repeat (ResetCycles) begin
			@(posedge clk);
			#1 expectTrue(!memReq && !outputValid && !halted, "outputs active during reset");
		end
		reset = 1'b0;
		outputCount = 0;
		firstRequest = 1'b1;
		@(negedge clk);
		expectTrue(!memReq && !outputValid && !halted, "outputs active right after reset");

		while (!halted) @(negedge clk);
		repeat (HaltWatch) begin
			@(negedge clk);
			expectTrue(halted && !memReq, "memory request or halt drop after HLT");
		end
		expectTrue(modelHalted, "reference model never reached HLT");
		expectTrue(outputCount == expectedCount,
			$sformatf("%0d WWD outputs, expected %0d", outputCount, expectedCount));
		for (int a = 128; a < 256; a++) begin
			expectTrue(mem[a] === modelMem[a],
				$sformatf("mem[%0d] is %h, expected %h", a, mem[a], modelMem[a]));
		end

		if (errorCount == errorsBefore) begin
			passCount++;
			$display("%s: passed, %0d outputs", name, outputCount);
		end else begin
			failCount++;
			$display("%s: failed with %0d errors", name, errorCount - errorsBefore);
		end
	endtask

	// Memory side of the four-phase handshake, 0 to 3 cycles per phase
	initial begin : memoryResponder
		logic [7:0] address;
		logic writeOp;
		logic [15:0] data;

		forever begin
			@(negedge clk);
			if (memReq && !memAck && !reset) begin
				address = memAddress[7:0];
				writeOp = memWrite;
				data = memWriteData;
				repeat (randRange(0, 3)) @(posedge clk);
				@(posedge clk);
				#1;
				memReadData = mem[address];
				if (writeOp) mem[address] = data;
				memAck = 1'b1;
				while (memReq) @(negedge clk);
				repeat (randRange(0, 3)) @(posedge clk);
				@(posedge clk);
				#1 memAck = 1'b0;
			end
		end
	end

	initial begin : busMonitor
		logic [15:0] expected;

		lastReq = 1'b0;
		lastAck = 1'b0;
		lastAddress = '0;
		forever begin
			@(negedge clk);
			if (!reset) begin
				if (memReq && !lastReq) begin
					expectTrue(!lastAck, "memReq rose while memAck was still high");
					if (firstRequest)
						expectTrue(memAddress == 0, $sformatf("first fetch from %h", memAddress));
					firstRequest = 1'b0;
				end
				if (memReq && lastReq)
					expectTrue(memAddress == lastAddress, "memAddress changed during a request");
				if (lastReq && !memReq)
					expectTrue(memAck, "memReq dropped before memAck");
				if (outputValid) begin
					outputCount++;
					expectTrue(modelOutputs.size() > 0, "WWD output the model does not have");
					if (modelOutputs.size() > 0) begin
						expected = modelOutputs.pop_front();
						expectTrue(outputPort == expected,
							$sformatf("WWD output %h, expected %h", outputPort, expected));
					end
				end
			end
			lastReq = memReq;
			lastAck = memAck;
			lastAddress = memAddress;
		end
	end

	initial begin : watchdog
		while (cycleCount <= cycleLimit) begin
			@(posedge clk);
			cycleCount++;
		end
		$display("Timeout: CPU did not halt within %0d cycles", cycleLimit);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		seed = 32'hc4c7;
		reset = 1'b1;
		memAck = 1'b0;
		memReadData = '0;
		firstRequest = 1'b0;
		errorCount = 0;
		passCount = 0;
		failCount = 0;
		runTest("aluImmediate", 0);
		runTest("loadStore", 1);
		runTest("controlFlow", 2);
		runTest("mixedBackPressure", 3);
		$display("Tests passed: %0d, failed: %0d", passCount, failCount);
		if (failCount == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// File: all.f
+incdir+bench
hw/tscPkg.sv
hw/ctrlBus.sv
hw/controlUnit.sv
hw/alu.sv
hw/registerFile.sv
hw/cpuDatapath.sv
hw/tscCpu.sv
bench/tscCpuTb.sv

// File: Bender.yml
package:
  name: tsc_cpu

sources:
  - files:
      - hw/tscPkg.sv
      - hw/ctrlBus.sv
      - hw/controlUnit.sv
      - hw/alu.sv
      - hw/registerFile.sv
      - hw/cpuDatapath.sv
      - hw/tscCpu.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tscCpuTb.sv
